// ==== common/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

   typedef logic [31:0] word_t;      // Data word
   typedef logic [31:2] addr_t;      // Word address
   typedef logic [5:0]  opcode_t;    // Major opcode
   typedef logic [15:0] imm_t;       // Immediate field
   typedef logic [4:0]  reg_idx_t;   // Register index

   // Architected MSR bits: EIP, EE, DTE, rsvd, ITE, MTX, BIP, C, IE, BE
   typedef logic [9:0]  msr_t;
   typedef logic [1:0]  esr_t;       // {illegal, data bus}
   typedef logic [2:0]  sfr_sel_t;   // Special register select

   // Major opcodes
   localparam opcode_t OPC_SHIFT = 6'o44;   // sra, src, srl, sext
   localparam opcode_t OPC_MOV   = 6'o45;   // mts, mfs, msrset, msrclr
   localparam opcode_t OPC_RET   = 6'o55;   // rtsd, rtid, rtbd, rted
   localparam opcode_t OPC_BRK   = 6'o56;   // brki

   // MSR bit positions
   localparam int MSR_EIP = 9;
   localparam int MSR_EE  = 8;
   localparam int MSR_RSV = 6;   // Reads as zero
   localparam int MSR_BIP = 3;
   localparam int MSR_C   = 2;
   localparam int MSR_IE  = 1;

   // Special register selects, low bits of the immediate
   localparam sfr_sel_t SEL_MSR = 3'd1;
   localparam sfr_sel_t SEL_EAR = 3'd3;
   localparam sfr_sel_t SEL_ESR = 3'd5;

   // ra codes of brki for each vector
   localparam reg_idx_t BRK_RA_BREAK = 5'hC;
   localparam reg_idx_t BRK_RA_INTR  = 5'hD;
   localparam reg_idx_t BRK_RA_EXC   = 5'hE;

   // Queue depth, also the sender's credit count
   localparam int BUF_DEPTH = 4;

endpackage

`default_nettype wire

// ==== common/issue_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One issued instruction, head of queue to the execute blocks
interface issue_if
   import exec_pkg::*;
   ();

   logic     valid;   // Instruction executes this cycle
   opcode_t  opc;
   word_t    opa;
   word_t    opb;
   word_t    opd;     // Store data, passed along
   imm_t     imm;
   reg_idx_t rd;
   reg_idx_t ra;

   modport producer (
      output valid, opc, opa, opb, opd, imm, rd, ra
   );

   modport consumer (
      input valid, opc, opa, opb, opd, imm, rd, ra
   );

endinterface

`default_nettype wire

// ==== verilog/issue_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_buffer
   import exec_pkg::*;
(
   input  logic      gclk,
   input  logic      grst,
   input  logic      ins_valid,
   input  opcode_t   ins_opc,
   input  word_t     ins_opa,
   input  word_t     ins_opb,
   input  word_t     ins_opd,
   input  imm_t      ins_imm,
   input  reg_idx_t  ins_rd,
   input  reg_idx_t  ins_ra,
   output logic      credit_ret,
   issue_if.producer iss
);

   logic [$clog2(BUF_DEPTH)-1:0] wr_ptr;   // Next free slot
   logic [$clog2(BUF_DEPTH)-1:0] rd_ptr;   // Head entry
   logic [$clog2(BUF_DEPTH):0]   count;    // Entries held
   logic                         pop;

   // Entry storage, one array per field
   opcode_t  q_opc [BUF_DEPTH];
   word_t    q_opa [BUF_DEPTH];
   word_t    q_opb [BUF_DEPTH];
   word_t    q_opd [BUF_DEPTH];
   imm_t     q_imm [BUF_DEPTH];
   reg_idx_t q_rd  [BUF_DEPTH];
   reg_idx_t q_ra  [BUF_DEPTH];

   // Stage never stalls, so the head leaves every cycle it exists
   assign pop        = (count != '0);
   assign credit_ret = pop;   // One credit back per issue

   always_ff @(posedge gclk) begin
      if (ins_valid) begin
         q_opc[wr_ptr] <= ins_opc;
         q_opa[wr_ptr] <= ins_opa;
         q_opb[wr_ptr] <= ins_opb;
         q_opd[wr_ptr] <= ins_opd;
         q_imm[wr_ptr] <= ins_imm;
         q_rd[wr_ptr]  <= ins_rd;
         q_ra[wr_ptr]  <= ins_ra;
      end
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (ins_valid) wr_ptr <= wr_ptr + 1'b1;   // Ring wraps at depth
         if (pop)       rd_ptr <= rd_ptr + 1'b1;
         case ({ins_valid, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;              // Both or neither
         endcase
      end
   end

   // Head entry straight to the execute blocks
   assign iss.valid = pop;
   assign iss.opc   = q_opc[rd_ptr];
   assign iss.opa   = q_opa[rd_ptr];
   assign iss.opb   = q_opb[rd_ptr];
   assign iss.opd   = q_opd[rd_ptr];
   assign iss.imm   = q_imm[rd_ptr];
   assign iss.rd    = q_rd[rd_ptr];
   assign iss.ra    = q_ra[rd_ptr];

endmodule

`default_nettype wire

// ==== intu/int_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_alu
   import exec_pkg::*;
(
   input  logic      gclk,
   input  logic      grst,
   issue_if.consumer iss,
   input  logic      carry,       // Current MSR carry
   output logic      add_c,       // Adder carry out
   output addr_t     mem_addr,    // Effective address, unregistered
   output logic      res_valid,
   output word_t     res_alu,
   output addr_t     res_mem,
   output addr_t     res_bpc
);

   logic  f_ccc;     // Carry in from MSR
   logic  f_sub;     // Reverse subtract
   logic  f_cmp;     // Unsigned compare
   logic  f_bra;     // Absolute branch
   logic  cin;
   logic  cmp_msb;
   word_t opa_sel;
   word_t sum;
   word_t add_res;
   word_t slm_res;   // Shift, logic, sign extend

   assign f_ccc = ~iss.opc[5] & iss.opc[1];
   assign f_sub = ~iss.opc[5] & iss.opc[0];
   assign f_cmp = ~iss.opc[3] & iss.imm[1];
   assign f_bra = ~iss.opc[0] & iss.ra[3];

   // rB + ~rA + 1 for subtract, so opb is the minuend
   assign opa_sel = f_sub ? ~iss.opa : iss.opa;
   assign cin     = f_ccc ? carry : f_sub;

   assign {add_c, sum} = {1'b0, iss.opb} + {1'b0, opa_sel} + {32'd0, cin};

   // Borrow for cmpu, plain sign for cmp
   assign cmp_msb = f_cmp ? ~add_c : sum[31];
   assign add_res = {cmp_msb, sum[30:0]};

   assign mem_addr = sum[31:2];

   always_comb begin
      case (iss.opc[2:0])
         3'o0: slm_res = iss.opa | iss.opb;
         3'o1: slm_res = iss.opa & iss.opb;
         3'o2: slm_res = iss.opa ^ iss.opb;
         3'o3: slm_res = iss.opa & ~iss.opb;    // andn
         3'o4: begin
            // Function code in imm[6:5] and imm[0]
            case ({iss.imm[6:5], iss.imm[0]})
               3'o1:    slm_res = {iss.opa[31], iss.opa[31:1]};        // sra
               3'o3:    slm_res = {carry, iss.opa[31:1]};              // src
               3'o5:    slm_res = {1'b0, iss.opa[31:1]};               // srl
               3'o6:    slm_res = {{24{iss.opa[7]}}, iss.opa[7:0]};    // sext8
               3'o7:    slm_res = {{16{iss.opa[15]}}, iss.opa[15:0]};  // sext16
               default: slm_res = '0;
            endcase
         end
         default: slm_res = '0;   // Moves and branches, no ALU value
      endcase
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         res_valid <= 1'b0;
         res_alu   <= '0;
         res_mem   <= '0;
         res_bpc   <= '0;
      end else begin
         res_valid <= iss.valid;
         if (iss.valid) begin
            res_alu <= iss.opc[5] ? slm_res : add_res;
            res_mem <= sum[31:2];                         // Load/store address
            res_bpc <= f_bra ? iss.opb[31:2] : sum[31:2]; // Else PC relative
         end
      end
   end

endmodule

`default_nettype wire

// ==== intu/sfr_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module sfr_unit
   import exec_pkg::*;
(
   input  logic      gclk,
   input  logic      grst,
   issue_if.consumer iss,
   input  logic      exc_ill,
   input  logic      exc_dwb,
   input  logic      add_c,      // From the adder
   input  addr_t     mem_addr,   // Faulting address
   output logic      carry,
   output word_t     res_sfr,
   output msr_t     res_msr
);

   msr_t     msr;
   addr_t    ear;
   esr_t     esr;
   msr_t     msr_nxt;
   msr_t     msr_op;    // msrset/msrclr value
   word_t    msr_word;  // MSR as read by mfs
   word_t    sfr_rd;
   sfr_sel_t sel;

   logic f_rtbd, f_brkb;   // Break
   logic f_rtid, f_brki;   // Interrupt
   logic f_rted, f_brke;   // Exception
   logic f_mov, f_mts, f_mop;
   logic f_shift, f_addsub;

   assign f_rtbd = (iss.opc == OPC_RET) & iss.rd[1];
   assign f_rtid = (iss.opc == OPC_RET) & iss.rd[0];
   assign f_rted = (iss.opc == OPC_RET) & iss.rd[2];
   assign f_brkb = (iss.opc == OPC_BRK) & (iss.ra == BRK_RA_BREAK);
   assign f_brki = (iss.opc == OPC_BRK) & (iss.ra == BRK_RA_INTR);
   assign f_brke = (iss.opc == OPC_BRK) & (iss.ra == BRK_RA_EXC);

   assign f_mov = (iss.opc == OPC_MOV);
   assign f_mts = f_mov & (&iss.imm[15:14]);
   assign f_mop = f_mov & ~(|iss.imm[15:14]);   // msrset/msrclr

   // sra, src, srl only; sext leaves the carry alone
   assign f_shift  = (iss.opc == OPC_SHIFT) & ~(iss.imm[6] & iss.imm[5]);
   assign f_addsub = ~iss.opc[5] & ~iss.opc[4] & ~iss.opc[2];

   assign msr_op = iss.ra[0] ? (msr & ~iss.imm[9:0])   // msrclr
                             : (msr | iss.imm[9:0]);   // msrset

   always_comb begin
      msr_nxt = msr;
      if (f_mts)
         msr_nxt = iss.opa[9:0];
      else if (f_mop)
         msr_nxt = msr_op;
      else if (f_shift)
         msr_nxt[MSR_C] = iss.opa[0];    // Bit shifted out
      else if (f_addsub)
         msr_nxt[MSR_C] = add_c;
      msr_nxt[MSR_RSV] = 1'b0;

      // Vector entry and return win over moves
      if (f_brkb)
         msr_nxt[MSR_BIP] = 1'b1;
      else if (f_rtbd)
         msr_nxt[MSR_BIP] = 1'b0;

      if (f_brki)
         msr_nxt[MSR_IE] = 1'b0;
      else if (f_rtid)
         msr_nxt[MSR_IE] = 1'b1;

      if (f_brke) begin
         msr_nxt[MSR_EE]  = 1'b0;
         msr_nxt[MSR_EIP] = 1'b1;
      end else if (f_rted) begin
         msr_nxt[MSR_EE]  = 1'b1;
         msr_nxt[MSR_EIP] = 1'b0;
      end
   end

   // Carry copy on top, thread and phase bits zero
   assign msr_word = {msr[MSR_C], 21'd0, msr};

   assign sel = iss.imm[2:0];

   always_comb begin
      case (sel)
         SEL_MSR: sfr_rd = msr_word;
         SEL_EAR: sfr_rd = {ear, 2'b00};
         SEL_ESR: sfr_rd = {30'd0, esr};
         default: sfr_rd = '0;
      endcase
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         msr     <= '0;
         ear     <= '0;
         esr     <= '0;
         res_sfr <= '0;
      end else if (iss.valid) begin
         msr     <= msr_nxt;
         res_sfr <= sfr_rd;                 // Value before this update
         if (exc_dwb)
            ear <= mem_addr;
         // Only logged while exceptions are enabled
         if ((exc_ill | exc_dwb) & msr[MSR_EE])
            esr <= {exc_ill, exc_dwb};
      end
   end

   assign carry   = msr[MSR_C];
   assign res_msr = msr;

endmodule

`default_nettype wire

// ==== verilog/exec_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_top
   import exec_pkg::*;
(
   input  logic     gclk,
   input  logic     grst,
   // Decoded instruction in
   input  logic     ins_valid,
   input  opcode_t  ins_opc,
   input  word_t    ins_opa,
   input  word_t    ins_opb,
   input  word_t    ins_opd,
   input  imm_t     ins_imm,
   input  reg_idx_t ins_rd,
   input  reg_idx_t ins_ra,
   // Exceptions, sampled with the issued instruction
   input  logic     exc_ill,
   input  logic     exc_dwb,
   output logic     credit_ret,
   // Results
   output logic     res_valid,
   output word_t    res_alu,
   output addr_t    res_mem,
   output addr_t    res_bpc,
   output word_t    res_sfr,
   output msr_t     res_msr
);

   issue_if iss ();

   logic  carry;      // MSR carry to the adder
   logic  add_c;      // Adder carry out to the MSR
   addr_t mem_addr;   // Effective address for EAR

   issue_buffer u_buf (
      .gclk       (gclk),
      .grst       (grst),
      .ins_valid  (ins_valid),
      .ins_opc    (ins_opc),
      .ins_opa    (ins_opa),
      .ins_opb    (ins_opb),
      .ins_opd    (ins_opd),
      .ins_imm    (ins_imm),
      .ins_rd     (ins_rd),
      .ins_ra     (ins_ra),
      .credit_ret (credit_ret),
      .iss        (iss.producer)
   );

   int_alu u_alu (
      .gclk      (gclk),
      .grst      (grst),
      .iss       (iss.consumer),
      .carry     (carry),
      .add_c     (add_c),
      .mem_addr  (mem_addr),
      .res_valid (res_valid),
      .res_alu   (res_alu),
      .res_mem   (res_mem),
      .res_bpc   (res_bpc)
   );

   sfr_unit u_sfr (
      .gclk     (gclk),
      .grst     (grst),
      .iss      (iss.consumer),
      .exc_ill  (exc_ill),
      .exc_dwb  (exc_dwb),
      .add_c    (add_c),
      .mem_addr (mem_addr),
      .carry    (carry),
      .res_sfr  (res_sfr),
      .res_msr  (res_msr)
   );

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

// Free running testbench clock
module tb_clock #(
   parameter realtime PERIOD = 40.0
) (
   output logic gclk
);

   initial gclk = 1'b0;

   always #(PERIOD / 2.0) gclk = ~gclk;   // 50% duty

endmodule

`default_nettype wire

// ==== test/tb_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_exec
   import exec_pkg::*;
   ();

   localparam int N_PAT = 41;                 // Lines in the pattern file
   localparam int LIMIT = N_PAT * 8 + 50;     // Cycle budget

   logic     gclk;
   logic     grst;
   logic     ins_valid;
   opcode_t  ins_opc;
   word_t    ins_opa;
   word_t    ins_opb;
   word_t    ins_opd;
   imm_t     ins_imm;
   reg_idx_t ins_rd;
   reg_idx_t ins_ra;
   logic     exc_ill;
   logic     exc_dwb;
   logic     credit_ret;
   logic     res_valid;
   word_t    res_alu;
   addr_t    res_mem;
   addr_t    res_bpc;
   word_t    res_sfr;
   msr_t     res_msr;

   logic [247:0] pats [0:N_PAT-1];   // One instruction plus expected results
   logic [247:0] exp_pat;
   int           expq [$];           // Pattern indices in flight
   int           exp_idx;
   int           sent;
   int           returned;           // credit_ret pulses seen
   int           recv;
   int           cycles;
   int           gap;
   integer       seed;

   tb_clock u_clk (.gclk(gclk));

   exec_top uut (.*);

   // Compare helpers, one per result type
   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (exp !== act) begin
         $display("[FAIL] %s expected %h actual %h", name, exp, act);
         $display("ERRORS FOUND");
         $fatal(1);
      end
   endtask

   task automatic check_addr(input string name, input addr_t exp, input addr_t act);
      if (exp !== act) begin
         $display("[FAIL] %s expected %h actual %h", name, exp, act);
         $display("ERRORS FOUND");
         $fatal(1);
      end
   endtask

   task automatic check_msr(input string name, input msr_t exp, input msr_t act);
      if (exp !== act) begin
         $display("[FAIL] %s expected %h actual %h", name, exp, act);
         $display("ERRORS FOUND");
         $fatal(1);
      end
   endtask

   // Put one pattern on the instruction inputs
   task automatic load_instr(input int idx);
      ins_opc = pats[idx][245:240];
      ins_opa = pats[idx][239:208];
      ins_opb = pats[idx][207:176];
      ins_imm = pats[idx][175:160];
      ins_rd  = pats[idx][156:152];
      ins_ra  = pats[idx][148:144];
      ins_opd = '0;
   endtask

   // Count credit returns and keep the exception inputs on the head entry
   always @(posedge gclk) begin
      if (!grst && credit_ret && returned >= sent) begin
         $display("Credit returned with no instruction outstanding");
         $display("ERRORS FOUND");
         $fatal(1);
      end else begin
         if (!grst && credit_ret)
            returned++;
         #2;
         if (returned < N_PAT) begin
            exc_ill = pats[returned][141];
            exc_dwb = pats[returned][140];
         end else begin
            exc_ill = 1'b0;
            exc_dwb = 1'b0;
         end
      end
   end

   // Results sampled at the edge hold the values of the cycle before
   always @(posedge gclk) begin
      if (!grst && res_valid) begin
         if (expq.size() == 0) begin
            $display("Result arrived with no instruction outstanding");
            $display("ERRORS FOUND");
            $fatal(1);
         end else begin
            exp_idx = expq.pop_front();
            exp_pat = pats[exp_idx];
            check_word($sformatf("pat %0d alu", exp_idx), exp_pat[139:108], res_alu);
            check_addr($sformatf("pat %0d mem", exp_idx), exp_pat[107:78], res_mem);
            check_addr($sformatf("pat %0d bpc", exp_idx), exp_pat[75:46], res_bpc);
            check_word($sformatf("pat %0d sfr", exp_idx), exp_pat[43:12], res_sfr);
            check_msr($sformatf("pat %0d msr", exp_idx), exp_pat[9:0], res_msr);
            recv++;
         end
      end
   end

   // Watchdog
   always @(posedge gclk) begin
      cycles++;
      if (cycles > LIMIT) begin
         $display("Timeout after %0d cycles, %0d of %0d results seen", cycles, recv, N_PAT);
         $display("ERRORS FOUND");
         $fatal(1);
      end
   end

   initial begin
      $readmemh("test/exec_patterns.mem", pats);
      seed      = 32'h1571;
      grst      = 1'b1;
      ins_valid = 1'b0;
      exc_ill   = 1'b0;
      exc_dwb   = 1'b0;
      sent      = 0;
      returned  = 0;
      recv      = 0;
      cycles    = 0;
      gap       = 0;
      load_instr(0);
      repeat (5) @(posedge gclk);
      #2 grst = 1'b0;

      while (sent < N_PAT) begin
         @(posedge gclk);
         #2;
         ins_valid = 1'b0;
         if (gap > 0)
            gap--;
         else if (sent - returned < BUF_DEPTH) begin   // Holding a credit
            load_instr(sent);
            ins_valid = 1'b1;
            expq.push_back(sent);
            sent++;
            // Bursts of four, then a random pause
            gap = (sent % 4 == 0) ? int'({$random(seed)} % 4) : 0;
         end
      end
      @(posedge gclk);
      #2 ins_valid = 1'b0;

      wait (recv == N_PAT);
      @(posedge gclk);
      if (returned != sent) begin
         $display("Credit count mismatch, %0d sent and %0d returned", sent, returned);
         $display("ERRORS FOUND");
         $fatal(1);
      end else begin
         $display("NO ERRORS");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== test/exec_patterns.mem ====
// opc_opa_opb_imm_rd_ra_exc{ill,dwb}_alu_mem_bpc_sfr_msr, all hex
// mem and bpc hold the byte address, bits 31:2 are compared
00_00000005_00000003_0000_03_00_0_00000008_00000008_00000008_00000000_000
00_FFFFFFFF_00000002_0000_03_00_0_00000001_00000001_00000001_00000000_004
02_00000010_00000020_0000_03_00_0_00000031_00000031_00000031_00000000_000
01_00000003_00000010_0000_03_00_0_0000000D_0000000D_0000000D_00000000_004
03_00000001_00000001_0000_03_00_0_00000000_00000000_00000000_00000000_004
05_00000005_00000003_0003_03_00_0_FFFFFFFE_FFFFFFFE_FFFFFFFE_00000000_004
05_00000003_80000000_0003_03_00_0_7FFFFFFD_7FFFFFFD_7FFFFFFD_00000000_004
05_00000001_FFFFFFFF_0001_03_00_0_FFFFFFFE_FFFFFFFE_FFFFFFFE_80000004_004
20_F0F00000_0000FF0F_0000_03_00_0_F0F0FF0F_F0F0FF0F_F0F0FF0F_00000000_004
21_12345678_0F0F0F0F_0000_03_00_0_02040608_21436587_21436587_00000000_004
22_AAAA5555_FFFF0000_0000_03_00_0_55555555_AAA95555_AAA95555_00000000_004
23_FFFF00FF_0F0F0F0F_0000_03_00_0_F0F000F0_0F0E100E_0F0E100E_00000000_004
24_80000003_00000000_0001_03_00_0_C0000001_80000003_80000003_80000004_004
24_00000002_00000000_0021_03_00_0_80000001_00000002_00000002_80000004_000
24_FFFFFFFE_00000000_0041_03_00_0_7FFFFFFF_FFFFFFFE_FFFFFFFE_00000000_000
24_00000080_00000000_0060_03_00_0_FFFFFF80_00000080_00000080_00000000_000
24_00017FFF_00000000_0061_03_00_0_00007FFF_00017FFF_00017FFF_00000000_000
26_00000000_00001000_0000_03_08_0_00000000_00001000_00001000_00000000_000
25_00000000_00000000_0100_03_00_0_00000000_00000000_00000000_00000000_100
32_00002000_00000024_0000_03_00_1_00002024_00002024_00002024_00000000_100
25_00000000_00000000_8003_03_00_0_00000000_00000000_00000000_00002024_100
25_00000000_00000000_0100_03_01_0_00000000_00000000_00000000_00000000_000
04_00000001_00000001_0000_03_00_2_00000002_00000002_00000002_00000000_000
25_00000000_00000000_8005_03_00_0_00000000_00000000_00000000_00000001_000
25_00000000_00000000_0100_03_00_0_00000000_00000000_00000000_00000000_100
04_00000001_00000001_0000_03_00_2_00000002_00000002_00000002_00000000_100
25_00000000_00000000_8005_03_00_0_00000000_00000000_00000000_00000002_100
2E_00000000_00000018_0000_03_0C_0_00000000_00000018_00000018_00000000_108
2D_00000100_00000004_0000_02_00_0_00000000_00000104_00000104_00000000_100
25_00000000_00000000_0002_03_00_0_00000000_00000000_00000000_00000000_102
2E_00000000_00000010_0000_03_0D_0_00000000_00000010_00000010_00000000_100
2D_00000200_00000000_0000_01_00_0_00000000_00000200_00000200_00000000_102
2E_00000000_00000020_0000_03_0E_0_00000000_00000020_00000020_00000000_202
2D_00000300_00000004_0000_04_00_0_00000000_00000304_00000304_00000000_102
25_000003FF_00000000_C001_03_00_0_00000000_000003FF_000003FF_00000102_3BF
25_00000000_00000000_8001_03_00_0_00000000_00000000_00000000_800003BF_3BF
02_00000001_00000001_0000_03_00_0_00000003_00000003_00000003_00000000_3BB
25_00000000_00000000_0100_03_01_0_00000000_00000000_00000000_00000000_2BB
36_00004000_00000008_0000_03_00_1_00000000_00004008_00004008_00000000_2BB
25_00000000_00000000_8003_03_00_0_00000000_00000000_00000000_00004008_2BB
25_00000000_00000000_8005_03_00_0_00000000_00000000_00000000_00000002_2BB

// ==== filelist.f ====
common/exec_pkg.sv
common/issue_if.sv
verilog/issue_buffer.sv
intu/int_alu.sv
intu/sfr_unit.sv
verilog/exec_top.sv
test/tb_clock.sv
test/tb_exec.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLIST     ?= filelist.f
TOP       ?= tb_exec
RTL_TOP   ?= exec_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
